/* include/axi_params.svh */
/*
 * Shared widths and limits for the AXI4 master address port.
 * Include this header in every file that sizes a port or a counter
 * from these values; the types live in the package instead.
 */

`ifndef AXI_PARAMS_SVH
`define AXI_PARAMS_SVH

// Width of the AxADDR field
`define ADDR_WIDTH 32

// Fixed AxSIZE code, every transfer is one 4-byte word
`define AXSIZE_WORD 3'd2

// AXI4 field widths, set by the protocol and not meant to change
`define AXLEN_WIDTH 8
`define AXSIZE_WIDTH 3
`define AXBURST_WIDTH 2

// Address handshakes that may be issued but not yet answered, both sides together
`define MAX_OUTSTANDING 4
`define CREDIT_WIDTH 3

// Width of each issued-address counter
`define ISSUE_COUNT_WIDTH 16

`endif

/* logic/axi_pkg.sv */
/*
 * Types shared by the AXI4 master address port and its testbench.
 * Refer to these by scoped name, for example axi_pkg::BURST_INCR.
 */

`default_nettype none

`include "axi_params.svh"

package axi_pkg;

    // ------------------------------------------------------------------
    // AxBURST encodings as defined by AXI4
    // ------------------------------------------------------------------

    typedef enum logic [`AXBURST_WIDTH-1:0] {
        BURST_FIXED    = 2'b00,
        BURST_INCR     = 2'b01,
        BURST_WRAP     = 2'b10,
        BURST_RESERVED = 2'b11
    } axburst_e;

    // ------------------------------------------------------------------
    // Sequencer grant state
    // ------------------------------------------------------------------

    // Idle means no channel holds its enable
    typedef enum logic [1:0] {
        SEQ_IDLE  = 2'b00,
        SEQ_READ  = 2'b01,
        SEQ_WRITE = 2'b10
    } seq_state_e;

endpackage

`default_nettype wire

/* logic/axi_addr_channel.sv */
/*
 * One AXI4 address channel, used for both AR and AW.
 * The host loads address, length and burst with one-cycle write strobes,
 * then pulses system_start. The address goes out once the sequencer
 * raises control_enable, and control_done marks the handshake.
 * system_ready stays high whenever the channel is idle.
 */

`timescale 1ns/1ns
`default_nettype none

`include "axi_params.svh"

module axi_addr_channel (
    input  wire logic                         clock,
    input  wire logic                         rst_n,

    // Host side
    input  wire logic [`ADDR_WIDTH-1:0]       system_address,
    input  wire logic                         system_address_wren,
    input  wire logic [`AXLEN_WIDTH-1:0]      system_count,
    input  wire logic                         system_count_wren,
    input  wire axi_pkg::axburst_e            system_burst,
    input  wire logic                         system_burst_wren,
    input  wire logic                         system_start,
    output logic                              system_ready,

    // Sequencer side
    input  wire logic                         control_enable,
    output logic                              pending,
    output logic                              control_done,

    // AXI address bus
    output logic [`ADDR_WIDTH-1:0]            axaddr,
    output logic [`AXLEN_WIDTH-1:0]           axlen,
    output logic [`AXSIZE_WIDTH-1:0]          axsize,
    output axi_pkg::axburst_e                 axburst,
    output logic                              axvalid,
    input  wire logic                         axready
);

    // ------------------------------------------------------------------
    // Handshake and ready
    // ------------------------------------------------------------------

    // The address is presented only when the host has started and the sequencer agrees
    assign axvalid      = control_enable && pending;
    assign control_done = axvalid && axready;
    assign system_ready = !pending;

    // Word-wide transfers only
    assign axsize = `AXSIZE_WORD;

    // ------------------------------------------------------------------
    // Start latch
    // ------------------------------------------------------------------

    // A start pulse arms the channel until the handshake completes
    // Starts that arrive while armed are dropped
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            pending <= 1'b0;
        end else if (control_done) begin
            pending <= 1'b0;
        end else if (system_start) begin
            pending <= 1'b1;
        end
    end

    // ------------------------------------------------------------------
    // Persistent transaction parameters
    // ------------------------------------------------------------------

    // Host writes land only while idle, so an armed transaction keeps its fields
    // The values persist and are reused by the next start without new writes
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            axaddr  <= '0;
            axlen   <= '0;
            axburst <= axi_pkg::BURST_FIXED;
        end else if (!pending) begin
            if (system_address_wren) begin
                axaddr <= system_address;
            end
            if (system_count_wren) begin
                axlen <= system_count;
            end
            if (system_burst_wren) begin
                axburst <= system_burst;
            end
        end
    end

    // ------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------

    // The sequencer must hold its enable while the slave stalls
    assert property (@(posedge clock) disable iff (!rst_n)
        (axvalid && !axready) |=> control_enable);

    // A waiting address keeps valid and every field unchanged
    assert property (@(posedge clock) disable iff (!rst_n)
        (axvalid && !axready) |=> axvalid && $stable(axaddr) && $stable(axlen)
                                  && $stable(axburst));

endmodule

`default_nettype wire

/* logic/addr_sequencer.sv */
/*
 * Grants the AR and AW channels one at a time.
 * A pending channel is granted from idle when a credit is free; ties go
 * round-robin, write first after reset. Each handshake takes one shared
 * credit and bumps that side's issue counter, and response-done pulses
 * give credits back.
 */

`timescale 1ns/1ns
`default_nettype none

`include "axi_params.svh"

module addr_sequencer (
    input  wire logic                           clock,
    input  wire logic                           rst_n,
    input  wire logic                           read_pending,
    input  wire logic                           write_pending,
    input  wire logic                           read_done,
    input  wire logic                           write_done,
    input  wire logic                           read_response_done,
    input  wire logic                           write_response_done,
    output logic                                read_enable,
    output logic                                write_enable,
    output logic [`CREDIT_WIDTH-1:0]            credits_free,
    output logic [`ISSUE_COUNT_WIDTH-1:0]       read_issue_count,
    output logic [`ISSUE_COUNT_WIDTH-1:0]       write_issue_count
);

    axi_pkg::seq_state_e state;
    axi_pkg::seq_state_e state_next;

    // Set when the read side was granted most recently
    logic last_was_read;

    logic                        credit_available;
    logic [`CREDIT_WIDTH-1:0]    credits_taken;
    logic [`CREDIT_WIDTH-1:0]    credits_returned;

    // ------------------------------------------------------------------
    // Grant FSM
    // ------------------------------------------------------------------

    assign credit_available = (credits_free != '0);

    always_comb begin
        state_next = state;
        case (state)
            axi_pkg::SEQ_IDLE: begin
                // On a tie, the side that did not go last wins
                if (credit_available) begin
                    if (read_pending && write_pending) begin
                        state_next = last_was_read ? axi_pkg::SEQ_WRITE : axi_pkg::SEQ_READ;
                    end else if (read_pending) begin
                        state_next = axi_pkg::SEQ_READ;
                    end else if (write_pending) begin
                        state_next = axi_pkg::SEQ_WRITE;
                    end
                end
            end
            axi_pkg::SEQ_READ: begin
                if (read_done) begin
                    state_next = axi_pkg::SEQ_IDLE;
                end
            end
            axi_pkg::SEQ_WRITE: begin
                if (write_done) begin
                    state_next = axi_pkg::SEQ_IDLE;
                end
            end
            default: begin
                state_next = axi_pkg::SEQ_IDLE;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state         <= axi_pkg::SEQ_IDLE;
            last_was_read <= 1'b1;
        end else begin
            state <= state_next;
            if (state == axi_pkg::SEQ_IDLE && state_next != axi_pkg::SEQ_IDLE) begin
                last_was_read <= (state_next == axi_pkg::SEQ_READ);
            end
        end
    end

    // Enables decode straight from the state register
    assign read_enable  = (state == axi_pkg::SEQ_READ);
    assign write_enable = (state == axi_pkg::SEQ_WRITE);

    // ------------------------------------------------------------------
    // Credits and issue counters
    // ------------------------------------------------------------------

    // Only the granted side can complete, so at most one credit goes per edge
    assign credits_taken    = {{(`CREDIT_WIDTH-1){1'b0}}, read_done || write_done};
    assign credits_returned = {{(`CREDIT_WIDTH-1){1'b0}}, read_response_done}
                            + {{(`CREDIT_WIDTH-1){1'b0}}, write_response_done};

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            credits_free      <= `CREDIT_WIDTH'(`MAX_OUTSTANDING);
            read_issue_count  <= '0;
            write_issue_count <= '0;
        end else begin
            // A take and a return on the same edge cancel
            credits_free <= credits_free - credits_taken + credits_returned;
            if (read_done) begin
                read_issue_count <= read_issue_count + 1'b1;
            end
            if (write_done) begin
                write_issue_count <= write_issue_count + 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------

    // A handshake completes only on the side that holds the enable
    assert property (@(posedge clock) disable iff (!rst_n)
        (!read_done || read_enable) && (!write_done || write_enable));

    assert property (@(posedge clock) disable iff (!rst_n) credits_free <= `MAX_OUTSTANDING);

    // Responses may only answer handshakes that are still outstanding
    assert property (@(posedge clock) disable iff (!rst_n)
        (read_response_done || write_response_done) |->
            (credits_free + credits_returned <= `MAX_OUTSTANDING + credits_taken));

endmodule

`default_nettype wire

/* logic/axi_master_addr_port.sv */
/*
 * Address-issue half of a minimal AXI4 master.
 * Holds one read (AR) and one write (AW) address channel and the
 * sequencer that grants them in turn under a shared outstanding limit.
 * Host strobes use the read_ and write_ prefixes, the AXI buses ar_ and aw_.
 */

`timescale 1ns/1ns
`default_nettype none

`include "axi_params.svh"

module axi_master_addr_port (
    input  wire logic                         clock,
    input  wire logic                         rst_n,

    // Read host side
    input  wire logic [`ADDR_WIDTH-1:0]       read_address,
    input  wire logic                         read_address_wren,
    input  wire logic [`AXLEN_WIDTH-1:0]      read_count,
    input  wire logic                         read_count_wren,
    input  wire axi_pkg::axburst_e            read_burst,
    input  wire logic                         read_burst_wren,
    input  wire logic                         read_start,
    output logic                              read_ready,
    input  wire logic                         read_response_done,

    // Write host side
    input  wire logic [`ADDR_WIDTH-1:0]       write_address,
    input  wire logic                         write_address_wren,
    input  wire logic [`AXLEN_WIDTH-1:0]      write_count,
    input  wire logic                         write_count_wren,
    input  wire axi_pkg::axburst_e            write_burst,
    input  wire logic                         write_burst_wren,
    input  wire logic                         write_start,
    output logic                              write_ready,
    input  wire logic                         write_response_done,

    // AR bus
    output logic [`ADDR_WIDTH-1:0]            ar_addr,
    output logic [`AXLEN_WIDTH-1:0]           ar_len,
    output logic [`AXSIZE_WIDTH-1:0]          ar_size,
    output axi_pkg::axburst_e                 ar_burst,
    output logic                              ar_valid,
    input  wire logic                         ar_ready,

    // AW bus
    output logic [`ADDR_WIDTH-1:0]            aw_addr,
    output logic [`AXLEN_WIDTH-1:0]           aw_len,
    output logic [`AXSIZE_WIDTH-1:0]          aw_size,
    output axi_pkg::axburst_e                 aw_burst,
    output logic                              aw_valid,
    input  wire logic                         aw_ready,

    // Status
    output logic [`CREDIT_WIDTH-1:0]          credits_free,
    output logic [`ISSUE_COUNT_WIDTH-1:0]     read_issue_count,
    output logic [`ISSUE_COUNT_WIDTH-1:0]     write_issue_count
);

    // Channel to sequencer handshake
    logic read_pending;
    logic read_done;
    logic read_enable;
    logic write_pending;
    logic write_done;
    logic write_enable;

    axi_addr_channel u_read_channel (
        .clock(clock), .rst_n(rst_n),
        .system_address(read_address), .system_address_wren(read_address_wren),
        .system_count(read_count), .system_count_wren(read_count_wren),
        .system_burst(read_burst), .system_burst_wren(read_burst_wren),
        .system_start(read_start), .system_ready(read_ready),
        .control_enable(read_enable), .pending(read_pending), .control_done(read_done),
        .axaddr(ar_addr), .axlen(ar_len), .axsize(ar_size), .axburst(ar_burst),
        .axvalid(ar_valid), .axready(ar_ready)
    );

    axi_addr_channel u_write_channel (
        .clock(clock), .rst_n(rst_n),
        .system_address(write_address), .system_address_wren(write_address_wren),
        .system_count(write_count), .system_count_wren(write_count_wren),
        .system_burst(write_burst), .system_burst_wren(write_burst_wren),
        .system_start(write_start), .system_ready(write_ready),
        .control_enable(write_enable), .pending(write_pending), .control_done(write_done),
        .axaddr(aw_addr), .axlen(aw_len), .axsize(aw_size), .axburst(aw_burst),
        .axvalid(aw_valid), .axready(aw_ready)
    );

    // Grants one channel at a time and keeps the shared credit count
    addr_sequencer u_sequencer (
        .clock(clock), .rst_n(rst_n),
        .read_pending(read_pending), .write_pending(write_pending),
        .read_done(read_done), .write_done(write_done),
        .read_response_done(read_response_done), .write_response_done(write_response_done),
        .read_enable(read_enable), .write_enable(write_enable),
        .credits_free(credits_free),
        .read_issue_count(read_issue_count), .write_issue_count(write_issue_count)
    );

endmodule

`default_nettype wire

/* verification/tb_axi_master_addr_port.sv */
/*
 * Testbench for the AXI4 master address port.
 * A cycle model of channels and sequencer predicts valid, ready, fields,
 * credits and counters, and a compare process checks the DUT every edge.
 */

`timescale 1ns/1ns
`default_nettype none

`include "axi_params.svh"

module tb_axi_master_addr_port;

    // Worst case per transaction is own stall, the other side's turn and 4 cycles
    localparam int MAX_STALL = 3;
    localparam int NUM_TRANSACTIONS = 83;
    localparam int CYCLE_LIMIT = NUM_TRANSACTIONS * (MAX_STALL + (MAX_STALL + 4) + 4) + 600;

    logic clock;
    logic rst_n;
    logic [`ADDR_WIDTH-1:0] read_address, write_address;
    logic [`AXLEN_WIDTH-1:0] read_count, write_count;
    axi_pkg::axburst_e read_burst, write_burst;
    logic read_address_wren, read_count_wren, read_burst_wren, read_start;
    logic write_address_wren, write_count_wren, write_burst_wren, write_start;
    logic read_response_done, write_response_done;
    logic read_ready, write_ready;
    logic [`ADDR_WIDTH-1:0] ar_addr, aw_addr;
    logic [`AXLEN_WIDTH-1:0] ar_len, aw_len;
    logic [`AXSIZE_WIDTH-1:0] ar_size, aw_size;
    axi_pkg::axburst_e ar_burst, aw_burst;
    logic ar_valid, aw_valid;
    logic ar_ready = 1'b1;
    logic aw_ready = 1'b1;
    logic [`CREDIT_WIDTH-1:0] credits_free;
    logic [`ISSUE_COUNT_WIDTH-1:0] read_issue_count, write_issue_count;

    // Model state is updated on each rising edge from the pre-edge values
    axi_pkg::seq_state_e m_state;
    logic m_last_read, m_pend_r, m_pend_w;
    int m_credits, m_reads, m_writes;
    logic [`ADDR_WIDTH-1:0] m_addr_r, m_addr_w;
    logic [`AXLEN_WIDTH-1:0] m_len_r, m_len_w;
    logic [`AXBURST_WIDTH-1:0] m_burst_r, m_burst_w;

    bit handshake_sides[$];
    bit stalls_on = 1'b0;
    int ar_left = 0;
    int aw_left = 0;
    int cycle_count = 0;

    axi_master_addr_port u_dut (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error at time %0t: %s is 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            $display("Result: FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // From idle with a credit a pending side is granted, and a tie goes to the side not
    // granted last
    function automatic axi_pkg::seq_state_e next_grant(input axi_pkg::seq_state_e state,
            input logic pend_r, input logic pend_w, input int credits,
            input logic last_read, input logic done_r, input logic done_w);
        axi_pkg::seq_state_e next;
        next = state;
        if (state == axi_pkg::SEQ_IDLE && credits > 0) begin
            if (pend_r && pend_w) begin
                next = last_read ? axi_pkg::SEQ_WRITE : axi_pkg::SEQ_READ;
            end else if (pend_r) begin
                next = axi_pkg::SEQ_READ;
            end else if (pend_w) begin
                next = axi_pkg::SEQ_WRITE;
            end
        end else if ((state == axi_pkg::SEQ_READ && done_r)
                     || (state == axi_pkg::SEQ_WRITE && done_w)) begin
            next = axi_pkg::SEQ_IDLE;
        end
        return next;
    endfunction

    // ------------------------------------------------------------------
    // Compare process and model step
    // ------------------------------------------------------------------

    always @(posedge clock) begin
        logic done_r;
        logic done_w;
        axi_pkg::seq_state_e next;
        if (!rst_n) begin
            m_state = axi_pkg::SEQ_IDLE;
            m_last_read = 1'b1;
            {m_pend_r, m_pend_w} = 2'b00;
            m_credits = `MAX_OUTSTANDING;
            m_reads = 0;
            m_writes = 0;
            {m_addr_r, m_addr_w, m_len_r, m_len_w, m_burst_r, m_burst_w} = '0;
        end else begin
            // Valid only while granted and armed, ready only while idle
            check_value("ar_valid", ar_valid, (m_state == axi_pkg::SEQ_READ) && m_pend_r);
            check_value("aw_valid", aw_valid, (m_state == axi_pkg::SEQ_WRITE) && m_pend_w);
            check_value("both valids high", ar_valid && aw_valid, 1'b0);
            check_value("read_ready", read_ready, !m_pend_r);
            check_value("write_ready", write_ready, !m_pend_w);
            check_value("credits_free", credits_free, m_credits);
            check_value("read_issue_count", read_issue_count, m_reads);
            check_value("write_issue_count", write_issue_count, m_writes);
            // Fields are checked every waiting cycle, which also covers stability
            if (ar_valid) begin
                check_value("ar_addr", ar_addr, m_addr_r);
                check_value("ar_len", ar_len, m_len_r);
                check_value("ar_size", ar_size, `AXSIZE_WORD);
                check_value("ar_burst", ar_burst, m_burst_r);
                if (ar_ready) handshake_sides.push_back(1'b0);
            end
            if (aw_valid) begin
                check_value("aw_addr", aw_addr, m_addr_w);
                check_value("aw_len", aw_len, m_len_w);
                check_value("aw_size", aw_size, `AXSIZE_WORD);
                check_value("aw_burst", aw_burst, m_burst_w);
                if (aw_ready) handshake_sides.push_back(1'b1);
            end

            done_r = (m_state == axi_pkg::SEQ_READ) && m_pend_r && ar_ready;
            done_w = (m_state == axi_pkg::SEQ_WRITE) && m_pend_w && aw_ready;
            next = next_grant(m_state, m_pend_r, m_pend_w, m_credits, m_last_read,
                              done_r, done_w);
            if (m_state == axi_pkg::SEQ_IDLE && next != axi_pkg::SEQ_IDLE) begin
                m_last_read = (next == axi_pkg::SEQ_READ);
            end
            m_state = next;
            m_credits = m_credits - int'(done_r || done_w) + int'(read_response_done)
                      + int'(write_response_done);
            m_reads += int'(done_r);
            m_writes += int'(done_w);
            // Shadow registers follow host writes only while that side is idle
            if (!m_pend_r && read_address_wren) m_addr_r = read_address;
            if (!m_pend_r && read_count_wren) m_len_r = read_count;
            if (!m_pend_r && read_burst_wren) m_burst_r = read_burst;
            if (!m_pend_w && write_address_wren) m_addr_w = write_address;
            if (!m_pend_w && write_count_wren) m_len_w = write_count;
            if (!m_pend_w && write_burst_wren) m_burst_w = write_burst;
            m_pend_r = !done_r && (m_pend_r || read_start);
            m_pend_w = !done_w && (m_pend_w || write_start);
        end
    end

    // The slave stalls each address for 0 to MAX_STALL cycles when enabled
    always @(negedge clock) begin
        ar_ready = !stalls_on || (ar_valid && ar_left == 0);
        aw_ready = !stalls_on || (aw_valid && aw_left == 0);
        if (!ar_valid) ar_left = $urandom % (MAX_STALL + 1);
        else if (ar_left > 0) ar_left--;
        if (!aw_valid) aw_left = $urandom % (MAX_STALL + 1);
        else if (aw_left > 0) aw_left--;
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("Timeout: the port did not finish its transactions in %0d cycles",
                     CYCLE_LIMIT);
            $display("Result: FAILED");
            $fatal(1, "timeout");
        end
    end

    // ------------------------------------------------------------------
    // Stimulus tasks start and end on a falling edge
    // ------------------------------------------------------------------

    task automatic load_params(input bit is_write, input logic [31:0] addr,
                               input logic [7:0] len, input axi_pkg::axburst_e burst);
        if (is_write) begin
            write_address = addr;
            write_count = len;
            write_burst = burst;
            {write_address_wren, write_count_wren, write_burst_wren} = 3'b111;
        end else begin
            read_address = addr;
            read_count = len;
            read_burst = burst;
            {read_address_wren, read_count_wren, read_burst_wren} = 3'b111;
        end
        @(negedge clock);
        {read_address_wren, read_count_wren, read_burst_wren} = 3'b000;
        {write_address_wren, write_count_wren, write_burst_wren} = 3'b000;
    endtask

    task automatic start_sides(input bit rd, input bit wr);
        read_start = rd;
        write_start = wr;
        @(negedge clock);
        {read_start, write_start} = 2'b00;
    endtask

    task automatic respond_sides(input bit rd, input bit wr);
        read_response_done = rd;
        write_response_done = wr;
        @(negedge clock);
        {read_response_done, write_response_done} = 2'b00;
    endtask

    task automatic wait_idle();
        while (!(read_ready && write_ready)) @(negedge clock);
    endtask

    initial begin
        int total_reads;
        int total_writes;
        int mix_start;
        int pick;
        bit rd;
        bit wr;
        void'($urandom(39));
        total_reads = 0;
        total_writes = 0;
        rst_n = 1'b0;
        {read_address, write_address, read_count, write_count} = '0;
        read_burst = axi_pkg::BURST_FIXED;
        write_burst = axi_pkg::BURST_FIXED;
        {read_address_wren, read_count_wren, read_burst_wren, read_start} = 4'b0000;
        {write_address_wren, write_count_wren, write_burst_wren, write_start} = 4'b0000;
        {read_response_done, write_response_done} = 2'b00;
        repeat (2) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;
        @(negedge clock);

        // Reset state, then one written read reused by a second start
        check_value("ar_addr after reset", ar_addr, 32'd0);
        check_value("ar_len after reset", ar_len, 32'd0);
        check_value("ar_burst after reset", ar_burst, axi_pkg::BURST_FIXED);
        check_value("aw_addr after reset", aw_addr, 32'd0);
        check_value("aw_len after reset", aw_len, 32'd0);
        check_value("aw_burst after reset", aw_burst, axi_pkg::BURST_FIXED);
        load_params(1'b0, 32'h1000_0040, 8'd3, axi_pkg::BURST_INCR);
        repeat (2) begin
            start_sides(1'b1, 1'b0);
            wait_idle();
            respond_sides(1'b1, 1'b0);
            total_reads++;
        end

        // A write strobe while pending is dropped, for this and the next start
        load_params(1'b1, 32'h2000_0100, 8'd7, axi_pkg::BURST_WRAP);
        start_sides(1'b0, 1'b1);
        load_params(1'b1, 32'hdead_0000, 8'd1, axi_pkg::BURST_FIXED);
        wait_idle();
        start_sides(1'b0, 1'b1);
        wait_idle();
        respond_sides(1'b0, 1'b1);
        respond_sides(1'b0, 1'b1);
        total_writes += 2;

        // Back-pressure on alternating sides
        stalls_on = 1'b1;
        for (int i = 0; i < 6; i++) begin
            load_params(i[0], 32'h3000_0000 + 32'(i * 64), 8'(i), axi_pkg::BURST_INCR);
            start_sides(!i[0], i[0]);
            wait_idle();
            respond_sides(!i[0], i[0]);
        end
        total_reads += 3;
        total_writes += 3;

        // Simultaneous starts must go round-robin
        // A single start of the side not served last sits between rounds, so a
        // fixed priority would serve one side twice in a row
        handshake_sides.delete();
        for (int i = 0; i < 3; i++) begin
            if (i > 0) begin
                rd = handshake_sides[$];
                wr = !rd;
                start_sides(rd, wr);
                wait_idle();
                respond_sides(rd, wr);
                total_reads += int'(rd);
                total_writes += int'(wr);
            end
            start_sides(1'b1, 1'b1);
            wait_idle();
            respond_sides(1'b1, 1'b1);
        end
        total_reads += 3;
        total_writes += 3;
        check_value("handshakes in both-started rounds", handshake_sides.size(), 8);
        for (int i = 1; i < 8; i++) begin
            check_value("round-robin side", handshake_sides[i], !handshake_sides[i-1]);
        end

        // Exhaust the credits, then let one response release one handshake
        stalls_on = 1'b0;
        repeat (`MAX_OUTSTANDING) begin
            start_sides(1'b1, 1'b0);
            wait_idle();
        end
        total_reads += `MAX_OUTSTANDING;
        start_sides(1'b0, 1'b1);
        repeat (6) @(negedge clock);
        check_value("credits_free with none left", credits_free, 32'd0);
        check_value("aw_valid with no credit", aw_valid, 1'b0);
        respond_sides(1'b1, 1'b0);
        wait_idle();
        total_writes++;
        check_value("credits_free after one release", credits_free, 32'd0);
        respond_sides(1'b1, 1'b1);
        respond_sides(1'b1, 1'b1);

        // Random mix of 60 transactions with random stalls and field reuse
        stalls_on = 1'b1;
        pick = 0;
        mix_start = total_reads + total_writes;
        while (total_reads + total_writes < mix_start + 60) begin
            rd = ($urandom % 3) != 1;
            wr = !rd || (($urandom % 2) && (total_reads + total_writes < mix_start + 59));
            if (rd && $urandom % 2) begin
                load_params(1'b0, $urandom, 8'($urandom), axi_pkg::axburst_e'(2'($urandom % 3)));
            end
            if (wr && $urandom % 2) begin
                load_params(1'b1, $urandom, 8'($urandom), axi_pkg::axburst_e'(2'($urandom % 3)));
            end
            start_sides(rd, wr);
            wait_idle();
            respond_sides(rd, wr);
            total_reads += int'(rd);
            total_writes += int'(wr);
            pick++;
        end
        check_value("final read_issue_count", read_issue_count, total_reads);
        check_value("final write_issue_count", write_issue_count, total_writes);
        $display("Random mix ran %0d rounds", pick);
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+include
logic/axi_pkg.sv
logic/axi_addr_channel.sv
logic/addr_sequencer.sv
logic/axi_master_addr_port.sv
verification/tb_axi_master_addr_port.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the AXI address port testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_axi_master_addr_port -f compile.f > build.log 2>&1 \
    && ./obj_dir/Vtb_axi_master_addr_port > sim.log 2>&1 \
    || echo "Build or simulation exited with an error" >> sim.log

cat build.log sim.log

if grep -q "Result: FAILED" sim.log; then
    exit 1
fi
grep -q "Result: PASSED" sim.log || { echo "No pass line in sim.log"; exit 1; }
exit 0
